// ==== Bender.yml ====
package:
  name: pr_compute_unit

sources:
  # RTL, package first
  - src/pr_pkg.sv
  - src/pr_vertex_queue.sv
  - src/pr_edge_reader.sv
  - src/pr_rank_reader.sv
  - src/pr_cmd_arbiter.sv
  - src/pr_response_router.sv
  - src/pr_rank_accumulator.sv
  - src/pr_compute_unit.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verif/pr_compute_unit_assert.sv
      - verif/pr_compute_unit_tb.sv

// ==== pr_compute_unit.f ====
src/pr_pkg.sv
src/pr_vertex_queue.sv
src/pr_edge_reader.sv
src/pr_rank_reader.sv
src/pr_cmd_arbiter.sv
src/pr_response_router.sv
src/pr_rank_accumulator.sv
src/pr_compute_unit.sv
verif/pr_compute_unit_assert.sv
verif/pr_compute_unit_tb.sv

// ==== src/pr_cmd_arbiter.sv ====
// Read command arbiter: round-robin between edge and rank readers into a tagged command FIFO
`timescale 1ns/1ns

module pr_cmd_arbiter #(
	parameter int CMD_DEPTH = 8
) (
	input  logic              clock,
	input  logic              rstn,
	input  logic              edge_cmd_valid,
	input  pr_pkg::addr_t     edge_cmd_addr,
	output logic              edge_cmd_ready,
	input  logic              rank_cmd_valid,
	input  pr_pkg::addr_t     rank_cmd_addr,
	output logic              rank_cmd_ready,
	output logic              rd_cmd_request,
	output pr_pkg::addr_t     rd_cmd_addr,
	output pr_pkg::read_tag_t rd_cmd_tag,
	input  logic              rd_cmd_grant
);
	import pr_pkg::*;

	localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
	localparam int CNT_W = $clog2(CMD_DEPTH + 1);

	addr_t            addr_mem [CMD_DEPTH];
	read_tag_t        tag_mem  [CMD_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;
	logic             fifo_full;
	logic             rr_rank;
	logic             take_edge;
	logic             take_rank;
	logic             push;
	logic             pop;

	assign fifo_full = (fill == CNT_W'(CMD_DEPTH));

	// rr_rank set gives the rank reader priority when both ask
	assign edge_cmd_ready = !fifo_full && !(rank_cmd_valid && rr_rank);
	assign rank_cmd_ready = !fifo_full && !(edge_cmd_valid && !rr_rank);
	assign take_edge      = edge_cmd_valid && edge_cmd_ready;
	assign take_rank      = rank_cmd_valid && rank_cmd_ready;
	assign push           = take_edge || take_rank;

	assign rd_cmd_request = (fill != '0);
	assign rd_cmd_addr    = addr_mem[rd_ptr];
	assign rd_cmd_tag     = tag_mem[rd_ptr];
	assign pop            = rd_cmd_request && rd_cmd_grant;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			fill    <= '0;
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			rr_rank <= 1'b0;
		end else begin
			if (push && !pop) begin
				fill <= fill + 1'b1;
			end else if (!push && pop) begin
				fill <= fill - 1'b1;
			end
			if (push) begin
				wr_ptr  <= (wr_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
				// Winner drops to lowest priority
				rr_rank <= take_edge;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			addr_mem[wr_ptr] <= take_rank ? rank_cmd_addr : edge_cmd_addr;
			tag_mem[wr_ptr]  <= take_rank ? TAG_RANK : TAG_EDGE;
		end
	end

endmodule

// ==== src/pr_compute_unit.sv ====
// PageRank vertex-pull compute unit: edge and rank reads over one shared port, per-vertex sums
`timescale 1ns/1ns

module pr_compute_unit #(
	parameter int            VERTEX_DEPTH   = 16,
	parameter int            CMD_DEPTH      = 8,
	parameter int            NEIGHBOR_DEPTH = 4,
	parameter pr_pkg::addr_t RANK_BASE      = 24'h100000
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       vertex_valid,
	output logic                       vertex_ready,
	input  pr_pkg::vertex_id_t         vertex_id,
	input  pr_pkg::addr_t              edge_start,
	input  pr_pkg::edge_count_t        edge_count,
	output logic                       rd_cmd_request,
	input  logic                       rd_cmd_grant,
	output pr_pkg::addr_t              rd_cmd_addr,
	output pr_pkg::read_tag_t          rd_cmd_tag,
	input  logic                       rd_data_valid,
	input  pr_pkg::read_tag_t          rd_data_tag,
	input  pr_pkg::read_word_t         rd_data,
	output logic                       wr_valid,
	input  logic                       wr_grant,
	output pr_pkg::vertex_id_t         wr_vertex,
	output pr_pkg::rank_t              wr_sum,
	output logic [pr_pkg::COUNT_W-1:0] vertex_done_count,
	output logic [pr_pkg::COUNT_W-1:0] edge_done_count
);
	import pr_pkg::*;

	// Current job
	logic        job_valid;
	vertex_id_t  job_vertex;
	addr_t       job_start;
	edge_count_t job_count;
	logic        job_done;

	// Reader command ports
	logic        edge_cmd_valid;
	addr_t       edge_cmd_addr;
	logic        edge_cmd_ready;
	logic        rank_cmd_valid;
	addr_t       rank_cmd_addr;
	logic        rank_cmd_ready;
	logic        neighbor_pop;

	// Routed read data
	logic        edge_valid;
	read_word_t  edge_word;
	logic        rank_valid;
	read_word_t  rank_word;

	////////////////////////////////////////////////////////////////////////////
	// Job side
	////////////////////////////////////////////////////////////////////////////

	pr_vertex_queue #(.VERTEX_DEPTH(VERTEX_DEPTH)) u_vertex_queue (
		.clock(clock), .rstn(rstn),
		.vertex_valid(vertex_valid), .vertex_ready(vertex_ready),
		.vertex_id(vertex_id), .edge_start(edge_start), .edge_count(edge_count),
		.job_valid(job_valid), .job_vertex(job_vertex),
		.job_start(job_start), .job_count(job_count), .job_done(job_done)
	);

	pr_edge_reader #(.NEIGHBOR_DEPTH(NEIGHBOR_DEPTH)) u_edge_reader (
		.clock(clock), .rstn(rstn),
		.job_valid(job_valid), .job_start(job_start), .job_count(job_count),
		.cmd_valid(edge_cmd_valid), .cmd_addr(edge_cmd_addr), .cmd_ready(edge_cmd_ready),
		.neighbor_pop(neighbor_pop)
	);

	pr_rank_reader #(.NEIGHBOR_DEPTH(NEIGHBOR_DEPTH), .RANK_BASE(RANK_BASE)) u_rank_reader (
		.clock(clock), .rstn(rstn),
		.edge_valid(edge_valid), .edge_word(edge_word),
		.cmd_valid(rank_cmd_valid), .cmd_addr(rank_cmd_addr), .cmd_ready(rank_cmd_ready),
		.neighbor_pop(neighbor_pop)
	);

	////////////////////////////////////////////////////////////////////////////
	// Shared read port
	////////////////////////////////////////////////////////////////////////////

	pr_cmd_arbiter #(.CMD_DEPTH(CMD_DEPTH)) u_cmd_arbiter (
		.clock(clock), .rstn(rstn),
		.edge_cmd_valid(edge_cmd_valid), .edge_cmd_addr(edge_cmd_addr),
		.edge_cmd_ready(edge_cmd_ready),
		.rank_cmd_valid(rank_cmd_valid), .rank_cmd_addr(rank_cmd_addr),
		.rank_cmd_ready(rank_cmd_ready),
		.rd_cmd_request(rd_cmd_request), .rd_cmd_addr(rd_cmd_addr),
		.rd_cmd_tag(rd_cmd_tag), .rd_cmd_grant(rd_cmd_grant)
	);

	pr_response_router u_response_router (
		.clock(clock), .rstn(rstn),
		.rd_data_valid(rd_data_valid), .rd_data_tag(rd_data_tag), .rd_data(rd_data),
		.edge_valid(edge_valid), .edge_word(edge_word),
		.rank_valid(rank_valid), .rank_word(rank_word)
	);

	////////////////////////////////////////////////////////////////////////////
	// Result side
	////////////////////////////////////////////////////////////////////////////

	pr_rank_accumulator u_rank_accumulator (
		.clock(clock), .rstn(rstn),
		.job_valid(job_valid), .job_vertex(job_vertex), .job_count(job_count),
		.rank_valid(rank_valid), .rank_word(rank_word),
		.wr_valid(wr_valid), .wr_vertex(wr_vertex), .wr_sum(wr_sum), .wr_grant(wr_grant),
		.job_done(job_done),
		.vertex_done_count(vertex_done_count), .edge_done_count(edge_done_count)
	);

endmodule

// ==== src/pr_edge_reader.sv ====
// Edge list reader: walks the current vertex's edge list under an outstanding-read limit
`timescale 1ns/1ns

module pr_edge_reader #(
	parameter int NEIGHBOR_DEPTH = 4
) (
	input  logic                clock,
	input  logic                rstn,
	input  logic                job_valid,
	input  pr_pkg::addr_t       job_start,
	input  pr_pkg::edge_count_t job_count,
	output logic                cmd_valid,
	output pr_pkg::addr_t       cmd_addr,
	input  logic                cmd_ready,
	input  logic                neighbor_pop
);
	import pr_pkg::*;

	localparam int CREDIT_W = $clog2(NEIGHBOR_DEPTH + 1);

	edge_count_t         issue_idx;
	logic [CREDIT_W-1:0] outstanding;
	logic                issue;

	// Outstanding reads never exceed the neighbour buffer in the rank reader
	assign cmd_valid = job_valid && (issue_idx < job_count)
		&& (outstanding < CREDIT_W'(NEIGHBOR_DEPTH));
	assign cmd_addr  = job_start + ADDR_W'(issue_idx);
	assign issue     = cmd_valid && cmd_ready;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issue_idx <= '0;
		end else if (!job_valid) begin
			// Idle gap between jobs rewinds the walk
			issue_idx <= '0;
		end else if (issue) begin
			issue_idx <= issue_idx + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Credits, taken on issue and returned when the rank reader pops
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= '0;
		end else begin
			case ({issue, neighbor_pop})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

endmodule

// ==== src/pr_pkg.sv ====
// PageRank compute unit shared types: field widths, read tags and the read data word
package pr_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Field widths
	////////////////////////////////////////////////////////////////////////////

	localparam int VERTEX_W     = 16;
	localparam int ADDR_W       = 24;
	localparam int RANK_W       = 32;
	localparam int EDGE_COUNT_W = 16;
	// Width of the running completion counters
	localparam int COUNT_W      = 32;

	typedef logic [VERTEX_W-1:0]     vertex_id_t;
	typedef logic [ADDR_W-1:0]       addr_t;
	// Unsigned fixed point, sums wrap modulo 2^32
	typedef logic [RANK_W-1:0]       rank_t;
	typedef logic [EDGE_COUNT_W-1:0] edge_count_t;

	////////////////////////////////////////////////////////////////////////////
	// Read tags name the array a command or data word belongs to
	////////////////////////////////////////////////////////////////////////////

	typedef logic [0:0] read_tag_t;

	localparam read_tag_t TAG_EDGE = 1'b0;
	localparam read_tag_t TAG_RANK = 1'b1;

	////////////////////////////////////////////////////////////////////////////
	// Read data word, decoded by its tag
	////////////////////////////////////////////////////////////////////////////

	// Edge list entry keeps the neighbour in the low bits
	typedef union packed {
		struct packed {
			logic [RANK_W-VERTEX_W-1:0] pad;
			vertex_id_t                 vertex;
		} edge_entry;
		rank_t rank;
	} read_word_t;

endpackage

// ==== src/pr_rank_accumulator.sv ====
// Rank accumulator: sums neighbour contributions and holds the vertex result until granted
`timescale 1ns/1ns

module pr_rank_accumulator (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         job_valid,
	input  pr_pkg::vertex_id_t           job_vertex,
	input  pr_pkg::edge_count_t          job_count,
	input  logic                         rank_valid,
	input  pr_pkg::read_word_t           rank_word,
	output logic                         wr_valid,
	output pr_pkg::vertex_id_t           wr_vertex,
	output pr_pkg::rank_t                wr_sum,
	input  logic                         wr_grant,
	output logic                         job_done,
	output logic [pr_pkg::COUNT_W-1:0]   vertex_done_count,
	output logic [pr_pkg::COUNT_W-1:0]   edge_done_count
);
	import pr_pkg::*;

	rank_t       sum;
	edge_count_t received;

	// A zero-edge job completes as soon as it shows up
	assign wr_valid  = job_valid && (received == job_count);
	assign wr_vertex = job_vertex;
	assign wr_sum    = sum;
	assign job_done  = wr_valid && wr_grant;

	////////////////////////////////////////////////////////////////////////////
	// Sum and received count, cleared when the result leaves
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sum      <= '0;
			received <= '0;
		end else if (job_done) begin
			sum      <= '0;
			received <= '0;
		end else if (rank_valid) begin
			// Wraps modulo 2^32
			sum      <= sum + rank_word.rank;
			received <= received + 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else if (job_done) begin
			vertex_done_count <= vertex_done_count + 1'b1;
			edge_done_count   <= edge_done_count + COUNT_W'(job_count);
		end
	end

endmodule

// ==== src/pr_rank_reader.sv ====
// Rank reader: buffers neighbour numbers from edge entries and issues rank array reads
`timescale 1ns/1ns

module pr_rank_reader #(
	parameter int            NEIGHBOR_DEPTH = 4,
	parameter pr_pkg::addr_t RANK_BASE      = 24'h100000
) (
	input  logic               clock,
	input  logic               rstn,
	input  logic               edge_valid,
	input  pr_pkg::read_word_t edge_word,
	output logic               cmd_valid,
	output pr_pkg::addr_t      cmd_addr,
	input  logic               cmd_ready,
	output logic               neighbor_pop
);
	import pr_pkg::*;

	localparam int PTR_W = (NEIGHBOR_DEPTH > 1) ? $clog2(NEIGHBOR_DEPTH) : 1;
	localparam int CNT_W = $clog2(NEIGHBOR_DEPTH + 1);

	vertex_id_t       nb_mem [NEIGHBOR_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;

	// Space is guaranteed by the edge reader's credits
	assign cmd_valid    = (fill != '0);
	assign cmd_addr     = RANK_BASE + ADDR_W'(nb_mem[rd_ptr]);
	assign neighbor_pop = cmd_valid && cmd_ready;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			fill   <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (edge_valid && !neighbor_pop) begin
				fill <= fill + 1'b1;
			end else if (!edge_valid && neighbor_pop) begin
				fill <= fill - 1'b1;
			end
			if (edge_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(NEIGHBOR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (neighbor_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(NEIGHBOR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	// Word arrives as an edge list entry
	always_ff @(posedge clock) begin
		if (edge_valid) begin
			nb_mem[wr_ptr] <= edge_word.edge_entry.vertex;
		end
	end

endmodule

// ==== src/pr_response_router.sv ====
// Read data router: registers each returned word and steers it to its consumer by tag
`timescale 1ns/1ns

module pr_response_router (
	input  logic               clock,
	input  logic               rstn,
	input  logic               rd_data_valid,
	input  pr_pkg::read_tag_t  rd_data_tag,
	input  pr_pkg::read_word_t rd_data,
	output logic               edge_valid,
	output pr_pkg::read_word_t edge_word,
	output logic               rank_valid,
	output pr_pkg::read_word_t rank_word
);
	import pr_pkg::*;

	read_word_t word_q;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_valid <= 1'b0;
			rank_valid <= 1'b0;
		end else begin
			edge_valid <= rd_data_valid && (rd_data_tag == TAG_EDGE);
			rank_valid <= rd_data_valid && (rd_data_tag == TAG_RANK);
		end
	end

	always_ff @(posedge clock) begin
		if (rd_data_valid) begin
			word_q <= rd_data;
		end
	end

	// Same register feeds both sides, only one valid is ever raised
	assign edge_word = word_q;
	assign rank_word = word_q;

endmodule

// ==== src/pr_vertex_queue.sv ====
// Vertex job queue: buffers incoming jobs and presents one current job at a time
`timescale 1ns/1ns

module pr_vertex_queue #(
	parameter int VERTEX_DEPTH = 16
) (
	input  logic                clock,
	input  logic                rstn,
	input  logic                vertex_valid,
	output logic                vertex_ready,
	input  pr_pkg::vertex_id_t  vertex_id,
	input  pr_pkg::addr_t       edge_start,
	input  pr_pkg::edge_count_t edge_count,
	output logic                job_valid,
	output pr_pkg::vertex_id_t  job_vertex,
	output pr_pkg::addr_t       job_start,
	output pr_pkg::edge_count_t job_count,
	input  logic                job_done
);
	import pr_pkg::*;

	localparam int PTR_W = (VERTEX_DEPTH > 1) ? $clog2(VERTEX_DEPTH) : 1;
	localparam int CNT_W = $clog2(VERTEX_DEPTH + 1);

	vertex_id_t       id_mem    [VERTEX_DEPTH];
	addr_t            start_mem [VERTEX_DEPTH];
	edge_count_t      count_mem [VERTEX_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;
	logic [CNT_W-1:0] fill_next;
	logic             push;
	logic             load;
	logic             bypass;
	logic             fifo_push;
	logic             fifo_pop;
	logic             fifo_empty;

	assign push       = vertex_valid && vertex_ready;
	assign fifo_empty = (fill == '0);
	// Current job slot refills only after it has been empty for a cycle
	assign load       = !job_valid && (push || !fifo_empty);
	// Empty queue hands the incoming job straight to the current slot
	assign bypass     = load && fifo_empty;
	assign fifo_push  = push && !bypass;
	assign fifo_pop   = load && !fifo_empty;

	always_comb begin
		fill_next = fill;
		if (fifo_push && !fifo_pop) begin
			fill_next = fill + 1'b1;
		end else if (!fifo_push && fifo_pop) begin
			fill_next = fill - 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			fill         <= '0;
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			vertex_ready <= 1'b0;
			job_valid    <= 1'b0;
		end else begin
			fill         <= fill_next;
			vertex_ready <= (fill_next < CNT_W'(VERTEX_DEPTH));
			if (fifo_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(VERTEX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (fifo_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(VERTEX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (job_done) begin
				job_valid <= 1'b0;
			end else if (load) begin
				job_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (fifo_push) begin
			id_mem[wr_ptr]    <= vertex_id;
			start_mem[wr_ptr] <= edge_start;
			count_mem[wr_ptr] <= edge_count;
		end
		if (load) begin
			job_vertex <= bypass ? vertex_id  : id_mem[rd_ptr];
			job_start  <= bypass ? edge_start : start_mem[rd_ptr];
			job_count  <= bypass ? edge_count : count_mem[rd_ptr];
		end
	end

endmodule

// ==== verif/pr_compute_unit_assert.sv ====
// Handshake assertions for the PageRank compute unit's read command and result ports
`timescale 1ns/1ns

module pr_compute_unit_assert (
	input logic               clock,
	input logic               rstn,
	input logic               rd_cmd_request,
	input logic               rd_cmd_grant,
	input pr_pkg::addr_t      rd_cmd_addr,
	input pr_pkg::read_tag_t  rd_cmd_tag,
	input logic               wr_valid,
	input logic               wr_grant,
	input pr_pkg::vertex_id_t wr_vertex,
	input pr_pkg::rank_t      wr_sum
);

	// Number of assertion failures so far
	int unsigned failures = 0;

	// Command stays up and unchanged until the memory takes it
	property cmd_held_until_grant;
		@(posedge clock) disable iff (!rstn)
			rd_cmd_request && !rd_cmd_grant |=>
				rd_cmd_request && $stable(rd_cmd_addr) && $stable(rd_cmd_tag);
	endproperty

	// Result is held until the sink grants it
	property result_held_until_grant;
		@(posedge clock) disable iff (!rstn)
			wr_valid && !wr_grant |=> wr_valid && $stable(wr_vertex) && $stable(wr_sum);
	endproperty

	// One cycle after reset is seen, the request line is clear
	property no_request_in_reset;
		@(posedge clock) !rstn |=> !rd_cmd_request;
	endproperty

	cmd_held_check: assert property (cmd_held_until_grant)
		else begin
			$error("rd_cmd_request dropped or changed before it was granted");
			failures++;
		end
	result_held_check: assert property (result_held_until_grant)
		else begin
			$error("wr_valid dropped or result changed before it was granted");
			failures++;
		end
	reset_request_check: assert property (no_request_in_reset)
		else begin
			$error("rd_cmd_request high during reset");
			failures++;
		end

endmodule

bind pr_compute_unit pr_compute_unit_assert u_handshake_assert (.*);

// ==== verif/pr_compute_unit_tb.sv ====
// Testbench for the PageRank compute unit: random jobs, memory model and per-vertex sum checks
`timescale 1ns/1ns

module pr_compute_unit_tb;
	import pr_pkg::*;

	localparam int    VERTEX_DEPTH = 16;
	localparam int    NUM_JOBS     = 40;
	localparam int    MAX_EDGES    = 6;
	localparam int    NUM_NB       = 64;
	localparam int    EDGE_WORDS   = 4096;
	localparam addr_t RANK_BASE    = 24'h100000;
	localparam int    WAIT_LIMIT   = 20000;

	logic               clock;
	logic               rstn;
	logic               vertex_valid;
	logic               vertex_ready;
	vertex_id_t         vertex_id;
	addr_t              edge_start;
	edge_count_t        edge_count;
	logic               rd_cmd_request;
	logic               rd_cmd_grant;
	addr_t              rd_cmd_addr;
	read_tag_t          rd_cmd_tag;
	logic               rd_data_valid;
	read_tag_t          rd_data_tag;
	read_word_t         rd_data;
	logic               wr_valid;
	logic               wr_grant;
	vertex_id_t         wr_vertex;
	rank_t              wr_sum;
	logic [COUNT_W-1:0] vertex_done_count;
	logic [COUNT_W-1:0] edge_done_count;

	logic [31:0] rng_state = 32'hf79e11d7;
	int          cycle;
	int          next_job;
	int          results_seen;
	int          total_edges;

	// Job table with the expected sum of each vertex
	vertex_id_t  job_id   [NUM_JOBS];
	addr_t       job_addr [NUM_JOBS];
	edge_count_t job_cnt  [NUM_JOBS];
	rank_t       job_sum  [NUM_JOBS];

	// Memory contents and the command stream expected from the unit
	vertex_id_t  edge_mem [EDGE_WORDS];
	rank_t       rank_val [NUM_NB];
	addr_t       exp_edge_addr [$];
	addr_t       exp_rank_addr [$];

	// Pending read data, one queue per tag so each tag keeps its order
	read_word_t  edge_resp_data [$];
	int          edge_resp_due  [$];
	read_word_t  rank_resp_data [$];
	int          rank_resp_due  [$];

	pr_compute_unit #(
		.VERTEX_DEPTH(VERTEX_DEPTH),
		.RANK_BASE(RANK_BASE)
	) DUT (.*);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic int random_below(int n);
		logic [31:0] r;
		r = next_random();
		return int'(r[31:8] % n);
	endfunction

	task automatic stop_on_failure(string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
		string line;
		if (got !== expected) begin
			line = $sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, expected);
			stop_on_failure(line);
		end
	endtask

	task automatic check_reset_outputs();
		check_value("vertex_ready", vertex_ready, 0);
		check_value("rd_cmd_request", rd_cmd_request, 0);
		check_value("wr_valid", wr_valid, 0);
		check_value("vertex_done_count", vertex_done_count, 0);
		check_value("edge_done_count", edge_done_count, 0);
	endtask

	// Every tenth job from index 3 has no edges
	task automatic build_jobs();
		addr_t      cursor;
		vertex_id_t nb;
		cursor      = 24'h000010;
		total_edges = 0;
		for (int n = 0; n < NUM_NB; n++) begin
			rank_val[n] = next_random();
		end
		for (int j = 0; j < NUM_JOBS; j++) begin
			job_id[j]   = vertex_id_t'(next_random());
			job_cnt[j]  = (j % 10 == 3) ? '0 : edge_count_t'(random_below(MAX_EDGES + 1));
			cursor      = cursor + addr_t'(random_below(8));
			job_addr[j] = cursor;
			job_sum[j]  = '0;
			for (int i = 0; i < int'(job_cnt[j]); i++) begin
				nb = vertex_id_t'(random_below(NUM_NB));
				edge_mem[int'(cursor) + i] = nb;
				job_sum[j] = job_sum[j] + rank_val[nb];
				exp_edge_addr.push_back(cursor + addr_t'(i));
				exp_rank_addr.push_back(RANK_BASE + addr_t'(nb));
			end
			cursor      = cursor + addr_t'(job_cnt[j]);
			total_edges = total_edges + int'(job_cnt[j]);
		end
	endtask

	// Bound handshake assertions stop the run at their first failure
	always @(posedge clock) begin
		if (DUT.u_handshake_assert.failures != 0) begin
			stop_on_failure("A handshake assertion on the read command or result port failed");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Vertex job source
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		if (rstn) begin
			if (vertex_valid && vertex_ready) begin
				next_job = next_job + 1;
			end
			// Queue plus current slot bound the jobs in flight
			if (next_job - results_seen > VERTEX_DEPTH + 1) begin
				stop_on_failure("More vertex jobs were taken than the queue can hold");
			end else if (!vertex_valid || vertex_ready) begin
				if (next_job < NUM_JOBS && random_below(4) != 0) begin
					vertex_valid <= 1'b1;
					vertex_id    <= job_id[next_job];
					edge_start   <= job_addr[next_job];
					edge_count   <= job_cnt[next_job];
				end else begin
					vertex_valid <= 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory model: random grants, random latency, in order per tag
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin : memory_model
		read_word_t word;
		logic       edge_due;
		logic       rank_due;
		cycle         = cycle + 1;
		rd_data_valid <= 1'b0;
		if (rstn) begin
			edge_due = (edge_resp_due.size() > 0) && (edge_resp_due[0] <= cycle);
			rank_due = (rank_resp_due.size() > 0) && (rank_resp_due[0] <= cycle);
			if (edge_due && (!rank_due || random_below(2) == 0)) begin
				rd_data_valid <= 1'b1;
				rd_data_tag   <= TAG_EDGE;
				rd_data       <= edge_resp_data.pop_front();
				void'(edge_resp_due.pop_front());
			end else if (rank_due) begin
				rd_data_valid <= 1'b1;
				rd_data_tag   <= TAG_RANK;
				rd_data       <= rank_resp_data.pop_front();
				void'(rank_resp_due.pop_front());
			end
			if (rd_cmd_request && rd_cmd_grant) begin
				if (rd_cmd_tag == TAG_EDGE && exp_edge_addr.size() == 0) begin
					stop_on_failure("Edge read issued after every edge list was read");
				end else if (rd_cmd_tag != TAG_EDGE && exp_rank_addr.size() == 0) begin
					stop_on_failure("Rank read issued with no neighbour left to read");
				end else if (rd_cmd_tag == TAG_EDGE) begin
					check_value("rd_cmd_addr (edge)", rd_cmd_addr, exp_edge_addr.pop_front());
					// Random padding must be ignored by the decode
					word.edge_entry.pad    = 16'(next_random() >> 8);
					word.edge_entry.vertex = edge_mem[int'(rd_cmd_addr)];
					edge_resp_data.push_back(word);
					edge_resp_due.push_back(cycle + 1 + random_below(6));
				end else begin
					check_value("rd_cmd_addr (rank)", rd_cmd_addr, exp_rank_addr.pop_front());
					word.rank = rank_val[int'(rd_cmd_addr - RANK_BASE)];
					rank_resp_data.push_back(word);
					rank_resp_due.push_back(cycle + 1 + random_below(6));
				end
			end
			rd_cmd_grant <= (random_below(8) > 2);
		end
	end

	// Result sink with a random grant
	always @(posedge clock) begin
		if (rstn) begin
			if (wr_valid && wr_grant) begin
				if (results_seen >= NUM_JOBS) begin
					stop_on_failure("More results were written than vertex jobs sent");
				end else begin
					check_value("wr_vertex", wr_vertex, job_id[results_seen]);
					check_value("wr_sum", wr_sum, job_sum[results_seen]);
					results_seen = results_seen + 1;
				end
			end
			wr_grant <= (random_below(3) != 0);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : main_sequence
		int waited;
		rstn          = 1'b0;
		vertex_valid  = 1'b0;
		vertex_id     = '0;
		edge_start    = '0;
		edge_count    = '0;
		rd_cmd_grant  = 1'b0;
		rd_data_valid = 1'b0;
		rd_data_tag   = TAG_EDGE;
		rd_data       = '0;
		wr_grant      = 1'b0;
		cycle         = 0;
		next_job      = 0;
		results_seen  = 0;
		build_jobs();

		repeat (16) begin
			@(negedge clock);
			check_reset_outputs();
		end
		@(posedge clock);
		rstn <= 1'b1;
		@(negedge clock);
		check_reset_outputs();

		waited = 0;
		while (results_seen < NUM_JOBS && waited < WAIT_LIMIT) begin
			@(negedge clock);
			waited = waited + 1;
		end
		if (results_seen < NUM_JOBS) begin
			stop_on_failure($sformatf("Timed out waiting for results, %0d of %0d written",
				results_seen, NUM_JOBS));
		end else begin
			check_value("vertex_done_count", vertex_done_count, NUM_JOBS);
			check_value("edge_done_count", edge_done_count, total_edges);
			check_value("edge reads not issued", exp_edge_addr.size(), 0);
			check_value("rank reads not issued", exp_rank_addr.size(), 0);
			if (DUT.u_handshake_assert.failures == 0) begin
				$display("RESULT: PASS");
				$finish;
			end else begin
				stop_on_failure("A handshake assertion failed near the end of the run");
			end
		end
	end

endmodule
